/* logic/frame_buffer.sv */
`timescale 1ns/1ps
`include "rx_cfg.svh"

module frame_buffer (
    input  logic                clk125MHz,
    input  logic                arst_n,
    input  logic                wr_en,
    input  rx_pkg::fifo_entry_t wr_entry,
    input  logic                rd_en,
    output rx_pkg::fifo_entry_t rd_entry,
    output logic                empty,
    output logic                loss
);

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    rx_pkg::fifo_entry_t mem [DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_write;
    logic        do_read;

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // head of queue, always visible
    assign rd_entry = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk125MHz or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            loss   <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // dropped write
            loss <= wr_en && full;
        end
    end

    always_ff @(posedge clk125MHz) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_entry;
        end
    end

endmodule

/* logic/frame_deframer.sv */
`timescale 1ns/1ps
`include "rx_cfg.svh"

module frame_deframer (
    input  logic                clk125MHz,
    input  logic                arst_n,
    input  rx_pkg::rx_byte_t    rx_in,
    output logic                wr_en,
    output rx_pkg::fifo_entry_t wr_entry
);

    rx_pkg::deframe_state_t state;
    logic                   valid_q;
    logic                   frame_start;
    logic [7:0]             held;
    logic                   held_valid;
    logic [31:0]            crc;
    logic [31:0]            crc_next;

    // reflected CRC-32, one byte lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0]  data);
        logic [31:0] c;
        c = crc_in ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 32'hEDB88320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next    = crc32_byte(crc, rx_in.data);
    // only a rising enable may open a frame
    assign frame_start = rx_in.valid && !valid_q;

    always_ff @(posedge clk125MHz or negedge arst_n) begin
        if (!arst_n) begin
            state      <= rx_pkg::idle;
            valid_q    <= 1'b0;
            held_valid <= 1'b0;
            crc        <= '1;
            wr_en      <= 1'b0;
        end else begin
            valid_q <= rx_in.valid;
            wr_en   <= 1'b0;
            case (state)
                rx_pkg::idle: begin
                    crc        <= '1;
                    held_valid <= 1'b0;
                    if (frame_start) begin
                        if (rx_in.data == 8'h55) begin
                            state <= rx_pkg::preamble;
                        end else if (rx_in.data == 8'hD5) begin
                            state <= rx_pkg::payload;
                        end
                    end
                end
                rx_pkg::preamble: begin
                    crc        <= '1;
                    held_valid <= 1'b0;
                    if (!rx_in.valid) begin
                        state <= rx_pkg::idle;
                    end else if (rx_in.data == 8'hD5) begin
                        state <= rx_pkg::payload;
                    end else if (rx_in.data != 8'h55) begin
                        // junk in the preamble, sit out the rest of it
                        state <= rx_pkg::idle;
                    end
                end
                rx_pkg::payload: begin
                    if (rx_in.valid) begin
                        crc        <= crc_next;
                        held_valid <= 1'b1;
                        wr_en      <= held_valid;
                    end else begin
                        // end of frame, flush the held byte
                        wr_en      <= held_valid;
                        held_valid <= 1'b0;
                        state      <= rx_pkg::idle;
                    end
                end
                default: state <= rx_pkg::idle;
            endcase
        end
    end

    // held byte and outgoing entry
    always_ff @(posedge clk125MHz) begin
        if (state == rx_pkg::payload) begin
            if (rx_in.valid) begin
                held     <= rx_in.data;
                wr_entry <= '{data: held, last: 1'b0, crc_ok: 1'b0};
            end else begin
                wr_entry <= '{data: held, last: 1'b1, crc_ok: (crc == `RX_CRC_RESIDUE)};
            end
        end
    end

endmodule

/* logic/frame_logger.sv */
`timescale 1ns/1ps
`include "rx_cfg.svh"

module frame_logger (
    input  logic                 clk125MHz,
    input  logic                 arst_n,
    input  rx_pkg::link_speed_t  speed,
    input  rx_pkg::fifo_entry_t  rd_entry,
    input  logic                 empty,
    output logic                 rd_en,
    output rx_pkg::rx_byte_t     out_byte,
    output logic                 frame_done,
    output logic                 frame_good,
    output logic                 started,
    output rx_pkg::frame_stats_t stats,
    input  logic                 loss,
    output logic                 led_good,
    output logic                 led_loss
);

    localparam int PW = $clog2(`RX_PACE_10);
    localparam int SW = $clog2(`RX_LED_STRETCH + 1);

    logic [PW-1:0] pace_cnt;
    logic          pace_tick;
    logic          out_valid;
    logic [7:0]    out_data;
    logic [1:0]    led_evt;
    logic [SW-1:0] led_cnt [2];

    // byte-advance counter per link rate
    always_ff @(posedge clk125MHz or negedge arst_n) begin
        if (!arst_n) begin
            pace_cnt <= '0;
        end else begin
            case (speed)
                rx_pkg::speed_100:
                    pace_cnt <= (pace_cnt >= PW'(`RX_PACE_100 - 1)) ? '0 : pace_cnt + 1'b1;
                rx_pkg::speed_10:
                    pace_cnt <= (pace_cnt >= PW'(`RX_PACE_10 - 1)) ? '0 : pace_cnt + 1'b1;
                default:
                    pace_cnt <= '0;
            endcase
        end
    end

    always_comb begin
        case (speed)
            rx_pkg::speed_1000: pace_tick = 1'b1;
            rx_pkg::speed_off:  pace_tick = 1'b0;
            default:            pace_tick = (pace_cnt == '0);
        endcase
    end

    assign rd_en = pace_tick && !empty;

    always_ff @(posedge clk125MHz or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            frame_done <= 1'b0;
            frame_good <= 1'b0;
            started    <= 1'b0;
            stats      <= '0;
        end else begin
            out_valid  <= rd_en;
            frame_done <= rd_en && rd_entry.last;
            frame_good <= rd_en && rd_entry.last && rd_entry.crc_ok;
            started    <= started || rd_en;
            if (rd_en && rd_entry.last) begin
                stats.frame_count <= stats.frame_count + 1'b1;
                if (rd_entry.crc_ok) begin
                    stats.good_count <= stats.good_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk125MHz) begin
        if (rd_en) begin
            out_data <= rd_entry.data;
        end
    end

    assign out_byte = '{data: out_data, valid: out_valid};

    // LED hold counters, index 0 good frames, 1 loss
    assign led_evt = {loss, frame_good};

    always_ff @(posedge clk125MHz or negedge arst_n) begin
        if (!arst_n) begin
            led_cnt[0] <= '0;
            led_cnt[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (led_evt[i]) begin
                    led_cnt[i] <= SW'(`RX_LED_STRETCH);
                end else if (led_cnt[i] != '0) begin
                    led_cnt[i] <= led_cnt[i] - 1'b1;
                end
            end
        end
    end

    assign led_good = (led_cnt[0] != '0);
    assign led_loss = (led_cnt[1] != '0);

endmodule

/* logic/rx_cfg.svh */
`ifndef RX_CFG_SVH
`define RX_CFG_SVH

// buffer entries, power of two
`define RX_FIFO_DEPTH 64

// LED hold time in cycles, short for simulation
`define RX_LED_STRETCH 1000

// cycles per byte at the slower link rates
`define RX_PACE_100 10
`define RX_PACE_10 100

// CRC-32 register after a good frame with its FCS
`define RX_CRC_RESIDUE 32'hDEBB20E3

`endif

/* logic/rx_pkg.sv */
package rx_pkg;

    // deframer position within a frame
    typedef enum logic [1:0] {
        idle     = 2'b00,
        preamble = 2'b01,
        payload  = 2'b10
    } deframe_state_t;

    // drain pace, same coding as the link speed pins
    typedef enum logic [1:0] {
        speed_off  = 2'b00,
        speed_10   = 2'b01,
        speed_100  = 2'b10,
        speed_1000 = 2'b11
    } link_speed_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } rx_byte_t;

    // crc_ok only means something on the last entry
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       crc_ok;
    } fifo_entry_t;

    typedef struct packed {
        logic [31:0] frame_count;
        logic [31:0] good_count;
    } frame_stats_t;

endpackage

/* logic/rx_top.sv */
`timescale 1ns/1ps

module rx_top (
    input  logic                 clk125MHz,
    input  logic                 arst_n,
    input  rx_pkg::rx_byte_t     rx_in,
    input  rx_pkg::link_speed_t  speed,
    output rx_pkg::rx_byte_t     out_byte,
    output logic                 frame_done,
    output logic                 frame_good,
    output logic                 started,
    output rx_pkg::frame_stats_t stats,
    output logic                 led_good,
    output logic                 led_loss
);

    logic                wr_en;
    rx_pkg::fifo_entry_t wr_entry;
    logic                rd_en;
    rx_pkg::fifo_entry_t rd_entry;
    logic                empty;
    logic                loss;

    frame_deframer frame_deframer_inst (
        .clk125MHz (clk125MHz),
        .arst_n    (arst_n),
        .rx_in     (rx_in),
        .wr_en     (wr_en),
        .wr_entry  (wr_entry)
    );

    frame_buffer frame_buffer_inst (
        .clk125MHz (clk125MHz),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_entry  (wr_entry),
        .rd_en     (rd_en),
        .rd_entry  (rd_entry),
        .empty     (empty),
        .loss      (loss)
    );

    frame_logger frame_logger_inst (
        .clk125MHz  (clk125MHz),
        .arst_n     (arst_n),
        .speed      (speed),
        .rd_entry   (rd_entry),
        .empty      (empty),
        .rd_en      (rd_en),
        .out_byte   (out_byte),
        .frame_done (frame_done),
        .frame_good (frame_good),
        .started    (started),
        .stats      (stats),
        .loss       (loss),
        .led_good   (led_good),
        .led_loss   (led_loss)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the rx testbench with Verilator, run it and grade the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f verilog.f --top-module rx_tb -Mdir obj_dir -o rx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rx_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

/* verif/rx_tb.sv */
`timescale 1ns/1ps
`include "rx_cfg.svh"

module rx_tb;

    localparam int n_good     = 20;
    localparam int n_mixed    = 12;
    localparam int n_slow     = 3;
    // slow frames carry at most 12 payload bytes plus FCS
    localparam int slow_bytes = 16;
    localparam int watchdog_cycles = (n_good + n_mixed + 2 * n_slow + 1) * 200
        + n_slow * slow_bytes * (`RX_PACE_10 + `RX_PACE_100) + 2 * `RX_LED_STRETCH + 2000;

    logic                 clk125MHz;
    logic                 arst_n;
    rx_pkg::rx_byte_t     rx_in;
    rx_pkg::link_speed_t  speed;
    rx_pkg::rx_byte_t     out_byte;
    logic                 frame_done;
    logic                 frame_good;
    logic                 started;
    rx_pkg::frame_stats_t stats;
    logic                 led_good;
    logic                 led_loss;

    // scoreboard of expected bytes with a good flag per frame
    logic [7:0]       exp_bytes [$];
    logic             exp_last [$];
    logic             exp_good [$];
    logic [31:0]      frames_sent;
    logic [31:0]      good_sent;
    logic [31:0]      lfsr_state;
    rx_pkg::rx_byte_t exp_byte;
    logic             exp_l;
    logic             exp_g;

    rx_top rx_top_inst (
        .clk125MHz  (clk125MHz),
        .arst_n     (arst_n),
        .rx_in      (rx_in),
        .speed      (speed),
        .out_byte   (out_byte),
        .frame_done (frame_done),
        .frame_good (frame_good),
        .started    (started),
        .stats      (stats),
        .led_good   (led_good),
        .led_loss   (led_loss)
    );

    initial begin
        clk125MHz = 1'b0;
        forever #4 clk125MHz = ~clk125MHz;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_byte(input rx_pkg::rx_byte_t got, input rx_pkg::rx_byte_t exp);
        if (got.valid !== exp.valid) begin
            fail_run($sformatf("** Error: out_byte.valid got 0x%h expected 0x%h",
                               got.valid, exp.valid));
        end else if (exp.valid && got.data !== exp.data) begin
            fail_run($sformatf("** Error: out_byte.data got 0x%h expected 0x%h",
                               got.data, exp.data));
        end
    endtask

    task automatic check_frame(input logic done, input logic good,
                               input logic exp_done, input logic exp_ok);
        if (done !== exp_done) begin
            fail_run($sformatf("** Error: frame_done got 0x%h expected 0x%h", done, exp_done));
        end else if (good !== exp_ok) begin
            fail_run($sformatf("** Error: frame_good got 0x%h expected 0x%h", good, exp_ok));
        end
    endtask

    task automatic check_stats(input rx_pkg::frame_stats_t got, input rx_pkg::frame_stats_t exp);
        if (got.frame_count !== exp.frame_count) begin
            fail_run($sformatf("** Error: stats.frame_count got 0x%h expected 0x%h",
                               got.frame_count, exp.frame_count));
        end else if (got.good_count !== exp.good_count) begin
            fail_run($sformatf("** Error: stats.good_count got 0x%h expected 0x%h",
                               got.good_count, exp.good_count));
        end
    endtask

    task automatic verify_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic expect_totals();
        rx_pkg::frame_stats_t exp;
        exp.frame_count = frames_sent;
        exp.good_count  = good_sent;
        check_stats(stats, exp);
    endtask

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    // Ethernet FCS computed bit serially with the lsb of each byte first
    function automatic logic [31:0] crc32_ref(input logic [7:0] data [$]);
        logic [31:0] crc;
        logic        fb;
        crc = 32'hFFFF_FFFF;
        foreach (data[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ data[k][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic drive_byte(input logic [7:0] data, input logic valid);
        @(negedge clk125MHz);
        rx_in.data  = data;
        rx_in.valid = valid;
    endtask

    // keep is how many bytes are expected to reach the output
    task automatic send_frame(input int len, input logic bad, input int keep);
        logic [7:0]  body [$];
        logic [31:0] fcs;
        int          pos;
        for (int k = 0; k < len; k++) begin
            body.push_back(8'(rand_bits(8)));
        end
        fcs = crc32_ref(body);
        for (int k = 0; k < 4; k++) begin
            body.push_back(fcs[8*k +: 8]);
        end
        if (bad) begin
            pos       = len + rand_bits(2);
            body[pos] = body[pos] ^ {7'(rand_bits(7)), 1'b1};
        end
        for (int k = 0; k < keep; k++) begin
            exp_bytes.push_back(body[k]);
            exp_last.push_back(keep == body.size() && k == keep - 1);
        end
        if (keep == body.size()) begin
            exp_good.push_back(!bad);
            frames_sent = frames_sent + 1;
            if (!bad) begin
                good_sent = good_sent + 1;
            end
        end
        repeat (7) drive_byte(8'h55, 1'b1);
        drive_byte(8'hD5, 1'b1);
        foreach (body[k]) begin
            drive_byte(body[k], 1'b1);
        end
        // inter-frame gap
        repeat (2) drive_byte(8'h00, 1'b0);
    endtask

    task automatic wait_drained();
        while (exp_bytes.size() != 0) begin
            @(negedge clk125MHz);
        end
        // let any stray output show up
        repeat (4) @(negedge clk125MHz);
    endtask

    // compares every output cycle against the scoreboard
    always @(posedge clk125MHz) begin
        if (arst_n) begin
            if (out_byte.valid && exp_bytes.size() == 0) begin
                fail_run("out_byte.valid was raised while no byte was expected");
            end else if (out_byte.valid) begin
                exp_byte.data  = exp_bytes.pop_front();
                exp_byte.valid = 1'b1;
                exp_l          = exp_last.pop_front();
                exp_g          = 1'b0;
                if (exp_l) begin
                    exp_g = exp_good.pop_front();
                end
                check_byte(out_byte, exp_byte);
                check_frame(frame_done, frame_good, exp_l, exp_g);
            end else begin
                check_frame(frame_done, frame_good, 1'b0, 1'b0);
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk125MHz);
        fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                           watchdog_cycles));
    end

    initial begin
        int   len;
        logic bad;
        arst_n      = 1'b0;
        rx_in       = '0;
        speed       = rx_pkg::speed_1000;
        lfsr_state  = 32'd74;
        frames_sent = '0;
        good_sent   = '0;
        repeat (10) @(posedge clk125MHz);
        @(negedge clk125MHz);
        arst_n = 1'b1;
        repeat (3) @(negedge clk125MHz);

        // quiet after reset
        check_byte(out_byte, '0);
        check_frame(frame_done, frame_good, 1'b0, 1'b0);
        verify_level("started", started, 1'b0);
        verify_level("led_good", led_good, 1'b0);
        verify_level("led_loss", led_loss, 1'b0);
        expect_totals();

        // good frames back to back at full rate
        for (int i = 0; i < n_good; i++) begin
            len = 4 + rand_bits(6) % 37;
            send_frame(len, 1'b0, len + 4);
        end
        wait_drained();
        expect_totals();
        verify_level("started", started, 1'b1);

        // first frame is always bad and the last always good for the LED check
        for (int i = 0; i < n_mixed; i++) begin
            len = 4 + rand_bits(6) % 37;
            bad = (i == 0) || (i != n_mixed - 1 && rand_bits(2) == 0);
            send_frame(len, bad, len + 4);
        end
        wait_drained();
        expect_totals();
        verify_level("led_good", led_good, 1'b1);
        repeat (`RX_LED_STRETCH) @(negedge clk125MHz);
        verify_level("led_good", led_good, 1'b0);

        // slow drain of small frames that fit the buffer
        for (int s = 0; s < 2; s++) begin
            if (s == 0) begin
                speed = rx_pkg::speed_10;
            end else begin
                speed = rx_pkg::speed_100;
            end
            for (int i = 0; i < n_slow; i++) begin
                len = 4 + rand_bits(4) % 9;
                send_frame(len, 1'b0, len + 4);
            end
            wait_drained();
            expect_totals();
        end
        verify_level("led_loss", led_loss, 1'b0);

        // overflow with the drain stopped loses the tail of the frame
        speed = rx_pkg::speed_off;
        send_frame(`RX_FIFO_DEPTH + 16, 1'b0, `RX_FIFO_DEPTH);
        repeat (4) @(negedge clk125MHz);
        verify_level("led_loss", led_loss, 1'b1);
        if (exp_bytes.size() != `RX_FIFO_DEPTH) begin
            fail_run("bytes left the buffer while the drain was stopped");
        end
        speed = rx_pkg::speed_1000;
        wait_drained();
        expect_totals();

        $display("Regression passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/rx_pkg.sv
logic/frame_deframer.sv
logic/frame_buffer.sv
logic/frame_logger.sv
logic/rx_top.sv
verif/rx_tb.sv
